// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - hw

sources:
  - files:
      - hw/dcache_pkg.sv
      - hw/dcache_way_if.sv
      - hw/dcache_way.sv
      - hw/dcache_lookup.sv
      - hw/dcache_ctrl.sv
      - hw/dcache_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/dcache_tb.sv

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    // processor reads
    input  logic                        read_do,
    input  dcache_pkg::addr_t           read_address,
    output logic                        read_done,
    output dcache_pkg::word_t           read_data,
    // processor writes
    input  logic                        write_do,
    input  dcache_pkg::addr_t           write_address,
    input  dcache_pkg::word_t           write_data,
    input  dcache_pkg::byte_en_t        write_byteenable,
    output logic                        write_done,
    way_if.ctrl                         bus,
    // lookup results
    input  logic                        hit,
    input  dcache_pkg::way_idx_t        hit_way,
    input  dcache_pkg::way_idx_t        victim_way,
    input  logic                        victim_dirty,
    input  dcache_pkg::tag_t            victim_tag,
    input  dcache_pkg::line_t           victim_line,
    input  dcache_pkg::word_t           rd_word,
    input  dcache_pkg::line_t           merged_line,
    output logic                        touch,
    output dcache_pkg::way_idx_t        touch_way,
    output logic                        fill,
    output logic [`DCACHE_OFFSET_W-1:0] offset,
    output dcache_pkg::word_t           wdata,
    output dcache_pkg::byte_en_t        byteenable,
    // line fill
    output logic                        readline_do,
    output dcache_pkg::addr_t           readline_address,
    input  logic                        readline_done,
    // write back
    output logic                        writeline_do,
    output dcache_pkg::addr_t           writeline_address,
    output dcache_pkg::line_t           writeline_line,
    input  logic                        writeline_done,
    output logic                        busy
);
    import dcache_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nx;
    addr_t       req_addr;
    addr_t       in_addr;
    addr_t       cur_addr;
    logic        req_write;
    way_idx_t    vict;       // victim held across the miss
    logic        accept;
    logic        miss;

    // --------------------
    // request side
    assign accept   = (state == st_idle) && (read_do || write_do);
    assign in_addr  = write_do ? write_address : read_address;   // write wins
    assign cur_addr = accept ? in_addr : req_addr;
    assign miss     = (state == st_check) && !hit;

    assign bus.rd_do    = accept;
    assign bus.index    = cur_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign bus.tag      = cur_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign bus.wr_tag   = req_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign bus.wr_line  = merged_line;   // reads merge nothing, see zero byte enable
    assign bus.wr_dirty = req_write;

    assign offset    = req_addr[`DCACHE_OFFSET_W-1:0];
    assign read_data = rd_word;
    assign fill      = (state == st_read_line);
    assign busy      = (state != st_idle);

    // memory port, levels straight off the state
    assign readline_do      = (state == st_read_line);
    assign readline_address = {req_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W],
                               {`DCACHE_OFFSET_W{1'b0}}};
    assign writeline_do     = (state == st_write_back);

    // --------------------
    // next state and strobes
    always_comb begin
        state_nx    = state;
        bus.wr_mask = '0;
        touch       = 1'b0;
        touch_way   = hit_way;
        read_done   = 1'b0;
        write_done  = 1'b0;
        case (state)
            st_idle: begin
                if (accept) state_nx = st_check;
            end
            st_check: begin
                if (hit) begin
                    touch      = 1'b1;         // read hits age the set too
                    read_done  = !req_write;
                    write_done = req_write;
                    if (req_write) bus.wr_mask = way_mask_t'(1) << hit_way;
                    state_nx   = st_idle;
                end else if (victim_dirty) begin
                    state_nx = st_write_back;
                end else begin
                    state_nx = st_read_line;   // clean or empty victim
                end
            end
            st_write_back: begin
                if (writeline_done) state_nx = st_read_line;
            end
            st_read_line: begin
                if (readline_done) begin
                    bus.wr_mask = way_mask_t'(1) << vict;   // refill into victim
                    touch       = 1'b1;
                    touch_way   = vict;
                    read_done   = !req_write;
                    write_done  = req_write;
                    state_nx    = st_idle;
                end
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            req_write <= 1'b0;
            vict      <= '0;
        end else begin
            state <= state_nx;
            if (accept) req_write <= write_do;
            if (miss) vict <= victim_way;
        end
    end

    // request payload and write back line
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr   <= in_addr;
            wdata      <= write_data;
            byteenable <= write_do ? write_byteenable : '0;
        end
        if (miss && victim_dirty) begin
            writeline_address <= {victim_tag, req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W],
                                  {`DCACHE_OFFSET_W{1'b0}}};   // rebuilt from stored tag
            writeline_line    <= victim_line;
        end
    end

endmodule

// ==== hw/dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// processor side
`define DCACHE_ADDR_W   32  // byte address
`define DCACHE_WORD_W   32  // one aligned access

// line geometry
`define DCACHE_LINE_W   128
`define DCACHE_OFFSET_W 4   // byte within a line
`define DCACHE_INDEX_W  4   // 16 sets
`define DCACHE_WAYS     4

// whatever is left of the address above index and offset
`define DCACHE_TAG_W    (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

// ==== hw/dcache_lookup.sv ====
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_lookup (
    input  logic                        clk,
    input  logic                        arst_n,
    way_if.drain                        ways,
    input  logic                        touch,
    input  dcache_pkg::way_idx_t        touch_way,
    input  logic [`DCACHE_OFFSET_W-1:0] offset,
    input  dcache_pkg::word_t           wdata,
    input  dcache_pkg::byte_en_t        byteenable,
    input  logic                        fill,
    input  dcache_pkg::line_t           fill_line,
    output logic                        hit,
    output dcache_pkg::way_idx_t        hit_way,
    output dcache_pkg::way_idx_t        victim_way,
    output logic                        victim_dirty,
    output dcache_pkg::tag_t            victim_tag,
    output dcache_pkg::line_t           victim_line,
    output dcache_pkg::word_t           rd_word,
    output dcache_pkg::line_t           merged_line
);
    import dcache_pkg::*;

    localparam int sets  = 1 << `DCACHE_INDEX_W;
    localparam int bytes = `DCACHE_WORD_W / 8;

    plru_t [sets-1:0]            plru_mem;
    plru_t                       plru;
    way_idx_t                    plru_way;
    line_t                       base_line;
    logic [`DCACHE_OFFSET_W-3:0] word_sel;   // word within the line

    // --------------------
    // hit and victim
    always_comb begin
        hit     = |ways.hit;
        hit_way = '0;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (ways.hit[w]) hit_way = way_idx_t'(w);
        end
    end

    assign plru     = plru_mem[ways.index];
    assign plru_way = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};   // walk the tree

    // lowest invalid way first, tree choice only when the set is full
    always_comb begin
        victim_way = plru_way;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (!ways.valid[w]) victim_way = way_idx_t'(w);
        end
    end

    assign victim_dirty = ways.valid[victim_way] && ways.dirty[victim_way];
    assign victim_tag   = ways.q_tag[victim_way];
    assign victim_line  = ways.q_line[victim_way];

    // touched way becomes the one the tree points away from
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            plru_mem <= '0;
        end else if (touch) begin
            plru_mem[ways.index][0] <= ~touch_way[1];       // root, other half
            if (touch_way[1]) begin
                plru_mem[ways.index][2] <= ~touch_way[0];
            end else begin
                plru_mem[ways.index][1] <= ~touch_way[0];
            end
        end
    end

    // --------------------
    // word extract and merge
    assign word_sel  = offset[`DCACHE_OFFSET_W-1:2];
    assign base_line = fill ? fill_line : ways.q_line[hit_way];   // refill data wins
    assign rd_word   = base_line[word_sel*`DCACHE_WORD_W +: `DCACHE_WORD_W];

    always_comb begin
        merged_line = base_line;
        for (int b = 0; b < bytes; b++) begin
            if (byteenable[b]) begin
                merged_line[word_sel*`DCACHE_WORD_W + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

endmodule

// ==== hw/dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    // --------------------
    // datapath vectors
    typedef logic [`DCACHE_ADDR_W-1:0]       addr_t;
    typedef logic [`DCACHE_WORD_W-1:0]       word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0]     byte_en_t;   // one bit per byte lane
    typedef logic [`DCACHE_LINE_W-1:0]       line_t;
    typedef logic [`DCACHE_TAG_W-1:0]        tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0]      index_t;

    // --------------------
    // way selection
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_idx_t;
    typedef logic [`DCACHE_WAYS-1:0]         way_mask_t;
    typedef logic [`DCACHE_WAYS-2:0]         plru_t;      // tree nodes, root in bit 0

    // miss handling FSM
    typedef enum logic [1:0] {
        st_idle,
        st_check,       // ways present their entries
        st_write_back,  // dirty victim out to memory
        st_read_line    // waiting on the refill
    } ctrl_state_e;

endpackage

// ==== hw/dcache_top.sv ====
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 arst_n,
    // processor reads
    input  logic                 read_do,
    input  dcache_pkg::addr_t    read_address,
    output logic                 read_done,
    output dcache_pkg::word_t    read_data,
    // processor writes
    input  logic                 write_do,
    input  dcache_pkg::addr_t    write_address,
    input  dcache_pkg::word_t    write_data,
    input  dcache_pkg::byte_en_t write_byteenable,
    output logic                 write_done,
    // line fill
    output logic                 readline_do,
    output dcache_pkg::addr_t    readline_address,
    input  logic                 readline_done,
    input  dcache_pkg::line_t    readline_line,
    // write back
    output logic                 writeline_do,
    output dcache_pkg::addr_t    writeline_address,
    output dcache_pkg::line_t    writeline_line,
    input  logic                 writeline_done,
    output logic                 busy
);
    import dcache_pkg::*;

    way_if bus ();

    // lookup to controller
    logic                        hit;
    way_idx_t                    hit_way;
    way_idx_t                    victim_way;
    logic                        victim_dirty;
    tag_t                        victim_tag;
    line_t                       victim_line;
    word_t                       rd_word;
    line_t                       merged_line;
    // controller to lookup
    logic                        touch;
    way_idx_t                    touch_way;
    logic                        fill;
    logic [`DCACHE_OFFSET_W-1:0] offset;
    word_t                       wdata;
    byte_en_t                    byteenable;

    dcache_ctrl u_ctrl (
        .clk               (clk),
        .arst_n            (arst_n),
        .read_do           (read_do),
        .read_address      (read_address),
        .read_done         (read_done),
        .read_data         (read_data),
        .write_do          (write_do),
        .write_address     (write_address),
        .write_data        (write_data),
        .write_byteenable  (write_byteenable),
        .write_done        (write_done),
        .bus               (bus),
        .hit               (hit),
        .hit_way           (hit_way),
        .victim_way        (victim_way),
        .victim_dirty      (victim_dirty),
        .victim_tag        (victim_tag),
        .victim_line       (victim_line),
        .rd_word           (rd_word),
        .merged_line       (merged_line),
        .touch             (touch),
        .touch_way         (touch_way),
        .fill              (fill),
        .offset            (offset),
        .wdata             (wdata),
        .byteenable        (byteenable),
        .readline_do       (readline_do),
        .readline_address  (readline_address),
        .readline_done     (readline_done),
        .writeline_do      (writeline_do),
        .writeline_address (writeline_address),
        .writeline_line    (writeline_line),
        .writeline_done    (writeline_done),
        .busy              (busy)
    );

    // --------------------
    // one storage block per way
    for (genvar i = 0; i < `DCACHE_WAYS; i++) begin : g_way
        dcache_way #(
            .way_id (i)
        ) u_way (
            .clk    (clk),
            .arst_n (arst_n),
            .bus    (bus)
        );
    end

    dcache_lookup u_lookup (
        .clk          (clk),
        .arst_n       (arst_n),
        .ways         (bus),
        .touch        (touch),
        .touch_way    (touch_way),
        .offset       (offset),
        .wdata        (wdata),
        .byteenable   (byteenable),
        .fill         (fill),
        .fill_line    (readline_line),   // refill goes straight to the merge
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (victim_line),
        .rd_word      (rd_word),
        .merged_line  (merged_line)
    );

endmodule

// ==== hw/dcache_way.sv ====
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_way #(
    parameter int way_id = 0
) (
    input logic clk,
    input logic arst_n,
    way_if.way  bus
);
    import dcache_pkg::*;

    localparam int sets = 1 << `DCACHE_INDEX_W;

    logic [sets-1:0] valid_mem;
    logic [sets-1:0] dirty_mem;
    tag_t            tag_mem  [sets];
    line_t           line_mem [sets];

    logic  q_valid;
    logic  q_dirty;
    tag_t  q_tag;
    line_t q_line;
    tag_t  req_tag;     // tag of the access in flight
    logic  we;

    assign we = bus.wr_mask[way_id];

    // valid and dirty per set, plus their registered copies
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_mem <= '0;
            dirty_mem <= '0;
            q_valid   <= 1'b0;
            q_dirty   <= 1'b0;
        end else begin
            if (we) begin
                valid_mem[bus.index] <= 1'b1;
                dirty_mem[bus.index] <= bus.wr_dirty;   // set by writes, cleared by read fills
            end
            if (bus.rd_do) begin
                q_valid <= valid_mem[bus.index];
                q_dirty <= dirty_mem[bus.index];
            end
        end
    end

    // tag and line storage
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[bus.index]  <= bus.wr_tag;
            line_mem[bus.index] <= bus.wr_line;
        end
        if (bus.rd_do) begin
            q_tag   <= tag_mem[bus.index];
            q_line  <= line_mem[bus.index];
            req_tag <= bus.tag;
        end
    end

    // compare runs on the registered entry, so hit is valid in check
    assign bus.hit[way_id]    = q_valid && (q_tag == req_tag);
    assign bus.valid[way_id]  = q_valid;
    assign bus.dirty[way_id]  = q_dirty;
    assign bus.q_tag[way_id]  = q_tag;
    assign bus.q_line[way_id] = q_line;

endmodule

// ==== hw/dcache_way_if.sv ====
`timescale 1ns/10ps
`include "dcache_defs.svh"

interface way_if;
    import dcache_pkg::*;

    // --------------------
    // controller to ways
    logic      rd_do;     // read strobe, all ways at once
    index_t    index;     // set for both read and write
    tag_t      tag;       // request tag, sampled with rd_do
    way_mask_t wr_mask;   // at most one bit set
    line_t     wr_line;
    tag_t      wr_tag;
    logic      wr_dirty;

    // --------------------
    // ways back to lookup
    way_mask_t hit;       // each way drives its own bit
    way_mask_t valid;
    way_mask_t dirty;
    tag_t      q_tag  [`DCACHE_WAYS];
    line_t     q_line [`DCACHE_WAYS];

    modport ctrl (
        output rd_do, index, tag, wr_mask, wr_line, wr_tag, wr_dirty
    );

    modport way (
        input  rd_do, index, tag, wr_mask, wr_line, wr_tag, wr_dirty,
        output hit, valid, dirty, q_tag, q_line
    );

    // lookup side sees stored entries plus set index for its lru bits
    modport drain (
        input hit, valid, dirty, q_tag, q_line, index
    );

endinterface

// ==== sim.f ====
+incdir+hw
+incdir+verification
hw/dcache_pkg.sv
hw/dcache_way_if.sv
hw/dcache_way.sv
hw/dcache_lookup.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verification/dcache_tb.sv

// ==== verification/dcache_tests.svh ====
`ifndef DCACHE_TESTS_SVH
`define DCACHE_TESTS_SVH

// line base from tag and set, offset left at zero
function automatic addr_t line_addr(int tag, int set);
    return addr_t'((tag << (`DCACHE_INDEX_W + `DCACHE_OFFSET_W)) | (set << `DCACHE_OFFSET_W));
endfunction

// --------------------
// cold start
task automatic first_read_test();
    int    start_err;
    int    rl;
    int    cycles;
    word_t data;
    start_err = errors;
    check_value("busy after reset", busy, 1'b0);
    check_value("readline_do after reset", readline_do, 1'b0);
    check_value("writeline_do after reset", writeline_do, 1'b0);
    rl = n_readline;
    cache_read(32'h0000_1234, data, cycles);
    check_value("readline count", n_readline - rl, 1);
    check_value("readline address", last_rl_addr, 32'h0000_1234 & ~32'hf);   // line aligned
    check_value("first read data", data, word_t'(~32'h0000_1234));
    finish_test("first read", start_err);
endtask

task automatic repeat_read_test();
    int    start_err;
    int    rl;
    int    cycles;
    word_t data;
    start_err = errors;
    rl = n_readline;
    cache_read(32'h0000_1234, data, cycles);
    check_value("readline on a hit", n_readline - rl, 0);
    check_value("read hit latency", cycles, 1);
    check_value("read hit data", data, word_t'(~32'h0000_1234));
    finish_test("repeat read", start_err);
endtask

// --------------------
// write hit merge, then write miss to a clean set
task automatic write_test();
    int start_err;
    int rl;
    int wb;
    start_err = errors;
    write_word(32'h0000_1234, 32'ha5a5_5a5a, 4'b0101);
    expect_read(32'h0000_1234);
    rl = n_readline;
    wb = n_writeline;
    write_word(32'h0004_0078, 32'h1357_9bdf, 4'b1100);   // set 7, untouched so far
    check_value("readline on write miss", n_readline - rl, 1);
    check_value("writeline on write miss", n_writeline - wb, 0);
    expect_read(32'h0004_0078);
    expect_read(32'h0004_0074);                          // neighbour word from the fill
    finish_test("write", start_err);
endtask

task automatic eviction_test();
    int    start_err;
    int    wb;
    logic  in_set;
    addr_t victim;
    start_err = errors;
    for (int t = 0; t < 4; t++) begin
        write_word(line_addr(16'h100 + t, 9), 32'hc0de_0000 + t, 4'hf);   // all four dirty
    end
    wb = n_writeline;
    expect_read(line_addr(16'h104, 9));
    check_value("writeline count on fifth tag", n_writeline - wb, 1);
    victim = last_wb_addr;
    in_set = 1'b0;
    for (int t = 0; t < 4; t++) begin
        if (victim == line_addr(16'h100 + t, 9)) in_set = 1'b1;
    end
    check_value("write-back address in set", in_set, 1'b1);
    check_value("write-back line", last_wb_line, shadow_line(victim));
    expect_read(victim);                                 // comes back from memory
    finish_test("eviction", start_err);
endtask

// A touched last must survive the next miss
task automatic plru_test();
    int start_err;
    int rl;
    start_err = errors;
    for (int t = 0; t < 4; t++) begin
        expect_read(line_addr(16'h200 + t, 11));
    end
    expect_read(line_addr(16'h200, 11));
    expect_read(line_addr(16'h204, 11));
    rl = n_readline;
    expect_read(line_addr(16'h200, 11));
    check_value("readline on re-read of A", n_readline - rl, 0);
    finish_test("plru", start_err);
endtask

// --------------------
// mixed traffic, 16 tags in each of sets 12 to 14
task automatic random_test();
    int    start_err;
    addr_t addr;
    start_err = errors;
    for (int i = 0; i < 200; i++) begin
        addr = line_addr(16'h300 + $urandom_range(15, 0), 12 + $urandom_range(2, 0));
        addr = addr + 4 * $urandom_range(3, 0);
        if ($urandom_range(1, 0) == 1) begin
            write_word(addr, $urandom, byte_en_t'($urandom_range(15, 0)));
        end else begin
            expect_read(addr);
        end
    end
    finish_test("random", start_err);
endtask

`endif

// ==== verification/dcache_tb.sv ====
`timescale 1ns/10ps
`include "dcache_defs.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int timeout_cycles = 100;
    localparam int mem_aw         = 17;    // word address bits kept by the model

    logic     clk;
    logic     arst_n;
    logic     read_do;
    addr_t    read_address;
    logic     read_done;
    word_t    read_data;
    logic     write_do;
    addr_t    write_address;
    word_t    write_data;
    byte_en_t write_byteenable;
    logic     write_done;
    logic     readline_do;
    addr_t    readline_address;
    logic     readline_done;
    line_t    readline_line;
    logic     writeline_do;
    addr_t    writeline_address;
    line_t    writeline_line;
    logic     writeline_done;
    logic     busy;

    word_t mem    [1 << mem_aw];   // backing store, changed only by write-back
    word_t shadow [1 << mem_aw];   // what the processor should read
    int    errors      = 0;
    int    checks      = 0;
    int    n_readline  = 0;
    int    n_writeline = 0;
    addr_t last_rl_addr;
    addr_t last_wb_addr;
    line_t last_wb_line;

    dcache_top dcache_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int word_index(addr_t a);
        return int'(a[mem_aw+1:2]);
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return shadow[word_index(a)];
    endfunction

    function automatic line_t shadow_line(addr_t base);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[i*32 +: 32] = shadow_word(base + 4 * i);   // word 0 in the low bits
        end
        return l;
    endfunction

    // --------------------
    // memory model
    initial begin : memory_model
        int    delay;
        line_t line;
        readline_done  = 1'b0;
        writeline_done = 1'b0;
        readline_line  = '0;
        forever begin
            @(negedge clk);                  // levels are stable here
            delay = $urandom_range(8, 1);
            if (writeline_do) begin
                n_writeline++;
                last_wb_addr = writeline_address;
                last_wb_line = writeline_line;
                repeat (delay) @(posedge clk);
                #1;
                for (int i = 0; i < 4; i++) begin
                    mem[word_index(last_wb_addr + 4 * i)] = last_wb_line[i*32 +: 32];
                end
                writeline_done = 1'b1;
                @(posedge clk);
                #1;
                writeline_done = 1'b0;
            end else if (readline_do) begin
                n_readline++;
                last_rl_addr = readline_address;
                for (int i = 0; i < 4; i++) begin
                    line[i*32 +: 32] = mem[word_index(last_rl_addr + 4 * i)];
                end
                repeat (delay) @(posedge clk);
                #1;
                readline_line = line;
                readline_done = 1'b1;
                @(posedge clk);
                #1;
                readline_done = 1'b0;
            end
        end
    end

    task automatic check_value(string what, line_t got, line_t expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("ERR %0t ns: %s, got %0h expected %0h", $time, what, got, expected);
        end
    endtask

    // --------------------
    // processor side requests
    task automatic cache_read(addr_t addr, output word_t data, output int cycles);
        logic seen;
        @(posedge clk);
        #1;
        read_do      = 1'b1;
        read_address = addr;
        @(posedge clk);                      // accepted here
        #1;
        read_do = 1'b0;
        seen    = 1'b0;
        cycles  = 0;
        data    = 'x;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (read_done) begin
                seen = 1'b1;
                data = read_data;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: read of address %h never finished", addr);
        end
    endtask

    task automatic write_word(addr_t addr, word_t data, byte_en_t be);
        logic  seen;
        int    cycles;
        word_t w;
        @(posedge clk);
        #1;
        write_do         = 1'b1;
        write_address    = addr;
        write_data       = data;
        write_byteenable = be;
        @(posedge clk);
        #1;
        write_do = 1'b0;
        seen     = 1'b0;
        cycles   = 0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            seen = write_done;
        end
        if (!seen) begin
            errors++;
            $display("timeout: write to address %h never finished", addr);
        end
        w = shadow_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[b*8 +: 8] = data[b*8 +: 8];   // only enabled lanes change
        end
        shadow[word_index(addr)] = w;
    endtask

    task automatic expect_read(addr_t addr);
        word_t data;
        int    cycles;
        cache_read(addr, data, cycles);
        check_value($sformatf("read of %h", addr), data, shadow_word(addr));
    endtask

    task automatic finish_test(string name, int errors_at_start);
        if (errors == errors_at_start) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d failures", name, errors - errors_at_start);
        end
    endtask

    `include "dcache_tests.svh"

    initial begin
        void'($urandom(32'h9cffa4b2));
        arst_n           = 1'b0;
        read_do          = 1'b0;
        read_address     = '0;
        write_do         = 1'b0;
        write_address    = '0;
        write_data       = '0;
        write_byteenable = '0;
        for (int i = 0; i < (1 << mem_aw); i++) begin
            mem[i]    = ~addr_t'(i << 2);    // inverse of the byte address
            shadow[i] = ~addr_t'(i << 2);
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        first_read_test();
        repeat_read_test();
        write_test();
        eviction_test();
        plru_test();
        random_test();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
